//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = blackjackTb
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

//--- design/apbRegs.sv
/*
	apb slave for the engine
	command and card writes, status and count reads, full shoe error
*/
`timescale 1ns/1ps

module apbRegs
	import blackjackPkg::*;
#(
	parameter int SHOE_DEPTH = 32,
	localparam int LEVEL_W = $clog2(SHOE_DEPTH) + 1
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  apbReqT             i_apb,
	output logic [31:0]        o_prdata,
	output logic               o_pready,
	output logic               o_pslverr,
	output commandT            o_cmd,
	output logic               o_cardPush,
	output cardT               o_card,
	input  logic               i_shoeFull,
	input  logic [LEVEL_W-1:0] i_shoeLevel,
	input  gameStatusT         i_status,
	input  handInfoT           i_player,
	input  handInfoT           i_dealer
);

	logic access;
	logic wrAccess;
	logic cmdWrite;
	logic cardWrite;
	logic pslverr;
	logic [31:0] statusWord;
	logic [31:0] countsWord;

	// transfer completes in the access phase, no wait states
	assign access    = i_apb.psel && i_apb.penable;
	assign wrAccess  = access && i_apb.pwrite;
	assign cmdWrite  = wrAccess && i_apb.paddr == ADDR_CMD;
	assign cardWrite = wrAccess && i_apb.paddr == ADDR_CARD;

	// one cycle command pulse, legality is checked by the game
	assign o_cmd = cmdWrite ? commandT'(i_apb.pwdata[1:0]) : CMD_NONE;

	// card is dropped when the shoe is full
	assign o_cardPush = cardWrite && !i_shoeFull;
	assign o_card     = cardT'(i_apb.pwdata[3:0]);

	// error flag, updated on every access and held in between
	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset)
			pslverr <= 1'b0;
		else if (access)
			pslverr <= cardWrite && i_shoeFull;
	end

	assign o_pslverr = pslverr;
	assign o_pready  = 1'b1;

	// status word
	always_comb begin
		statusWord        = '0;
		statusWord[3:0]   = i_status.state;
		statusWord[5:4]   = i_status.turn;
		statusWord[6]     = i_status.done;
		statusWord[12:8]  = i_player.sum;
		statusWord[20:16] = i_dealer.sum;
	end

	// counts word, level zero extended
	always_comb begin
		countsWord       = '0;
		countsWord[2:0]  = i_player.count;
		countsWord[6:4]  = i_dealer.count;
		countsWord[15:8] = 8'(i_shoeLevel);
	end

	// read mux, live values of the current cycle
	always_comb begin
		o_prdata = '0;
		if (i_apb.psel && !i_apb.pwrite) begin
			case (i_apb.paddr)
				ADDR_STATUS: o_prdata = statusWord;
				ADDR_COUNTS: o_prdata = countsWord;
				default:     o_prdata = '0;
			endcase
		end
	end

	// access phase always follows a setup phase
	penableNeedsPsel: assert property (@(posedge i_clk) disable iff (i_reset)
		i_apb.penable |-> i_apb.psel)
		else $error("apbRegs: penable without psel");

endmodule

//--- design/blackjackGame.sv
/*
	round fsm of the engine
	deal sequence, player checks, dealer draw to 17, outcome and turn
*/
`timescale 1ns/1ps

module blackjackGame
	import blackjackPkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  commandT    i_cmd,
	input  logic       i_shoeEmpty,
	input  handInfoT   i_player,
	input  handInfoT   i_dealer,
	output logic       o_draw,
	output logic       o_playerTake,
	output logic       o_dealerTake,
	output logic       o_clearHands,
	output gameStatusT o_status
);

	gameStateT state;
	gameStateT nextState;
	turnT turn;
	logic resultState;
	logic dealAccepted;
	logic playerBlackjack;
	logic playerCharlie;
	logic dealerCharlie;
	logic dealerHits;

	assign resultState = state inside {S_RESULT_WIN, S_RESULT_LOSE, S_RESULT_TIE};

	// deal only between rounds, other commands are handled in the choice state
	assign dealAccepted = i_cmd == CMD_DEAL && (state == S_IDLE || resultState);

	// hand outcome detectors
	assign playerBlackjack = i_player.count == 3'd2 && i_player.sum == BLACKJACK_SUM;
	assign playerCharlie   = i_player.count == HAND_MAX && !i_player.busted;
	assign dealerCharlie   = i_dealer.count == HAND_MAX && !i_dealer.busted;

	// dealer strategy
	// draw below 17 until five cards are held
	assign dealerHits = i_dealer.sum < DEALER_STAND && i_dealer.count < HAND_MAX;

	// one card per cycle while the shoe has cards
	assign o_dealerTake = !i_shoeEmpty
		&& (state == S_DEAL_DEALER || (state == S_DRAW_TO_17 && dealerHits));
	assign o_playerTake = !i_shoeEmpty && state == S_DEAL_PLAYER;
	assign o_draw       = o_playerTake || o_dealerTake;

	// fresh hands for every accepted deal
	assign o_clearHands = dealAccepted;

	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset)
			state <= S_IDLE;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			// idle and results wait for the next deal
			S_IDLE, S_RESULT_WIN, S_RESULT_LOSE, S_RESULT_TIE: begin
				if (dealAccepted)
					nextState = S_DEAL_DEALER;
			end
			// single up card for the dealer
			S_DEAL_DEALER: begin
				if (o_dealerTake)
					nextState = S_DEAL_PLAYER;
			end
			// two cards on the deal, one card on a hit
			S_DEAL_PLAYER: begin
				if (o_playerTake && i_player.count != '0)
					nextState = S_CHECK_PLAYER_BJ;
			end
			S_CHECK_PLAYER_BJ:
				nextState = playerBlackjack ? S_RESULT_WIN : S_CHECK_PLAYER_BUST;
			S_CHECK_PLAYER_BUST:
				nextState = i_player.busted ? S_RESULT_LOSE : S_CHECK_PLAYER_5CC;
			S_CHECK_PLAYER_5CC:
				nextState = playerCharlie ? S_RESULT_WIN : S_PLAYER_CHOICE;
			// host decides, a stray deal is ignored
			S_PLAYER_CHOICE: begin
				if (i_cmd == CMD_HIT)
					nextState = S_DEAL_PLAYER;
				else if (i_cmd == CMD_STAND)
					nextState = S_DRAW_TO_17;
			end
			// sums lag a take by one cycle, so this is re-evaluated each card
			S_DRAW_TO_17: begin
				if (!dealerHits)
					nextState = S_CHECK_DEALER_BUST;
			end
			S_CHECK_DEALER_BUST:
				nextState = i_dealer.busted ? S_RESULT_WIN : S_CHECK_DEALER_5CC;
			S_CHECK_DEALER_5CC:
				nextState = dealerCharlie ? S_RESULT_LOSE : S_COMPARE_HANDS;
			S_COMPARE_HANDS: begin
				if (i_player.sum == i_dealer.sum)
					nextState = S_RESULT_TIE;
				else if (i_player.sum > i_dealer.sum)
					nextState = S_RESULT_WIN;
				else
					nextState = S_RESULT_LOSE;
			end
			default:
				nextState = S_IDLE;
		endcase
	end

	// turn follows the state groups
	always_comb begin
		case (state)
			// player phases
			S_DEAL_PLAYER,
			S_CHECK_PLAYER_BJ,
			S_CHECK_PLAYER_BUST,
			S_CHECK_PLAYER_5CC,
			S_PLAYER_CHOICE:
				turn = TURN_PLAYER;
			// dealer phases
			S_DEAL_DEALER,
			S_DRAW_TO_17,
			S_CHECK_DEALER_BUST,
			S_CHECK_DEALER_5CC:
				turn = TURN_DEALER;
			// idle, compare and results
			default:
				turn = TURN_NONE;
		endcase
	end

	assign o_status.state = state;
	assign o_status.turn  = turn;
	assign o_status.done  = resultState;

	// both hands share the shoe head, only one may latch it
	takesExclusive: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_playerTake && o_dealerTake))
		else $error("blackjackGame: player and dealer take together");

endmodule

//--- design/blackjackPkg.sv
/*
	shared types for the blackjack engine
	card and hand widths, fsm enums, status and apb bundles, register offsets
*/
package blackjackPkg;

	// rank 1 is ace, 13 is king, 0 means empty slot
	typedef logic [3:0] cardT;
	// wide enough for a busted total
	typedef logic [4:0] sumT;
	typedef logic [2:0] countT;

	typedef enum logic [3:0] {
		S_IDLE,
		S_DEAL_DEALER,
		S_DEAL_PLAYER,
		S_CHECK_PLAYER_BJ,
		S_CHECK_PLAYER_BUST,
		S_CHECK_PLAYER_5CC,
		S_PLAYER_CHOICE,
		S_DRAW_TO_17,
		S_CHECK_DEALER_BUST,
		S_CHECK_DEALER_5CC,
		S_COMPARE_HANDS,
		S_RESULT_WIN,
		S_RESULT_LOSE,
		S_RESULT_TIE
	} gameStateT;

	typedef enum logic [1:0] {TURN_NONE, TURN_PLAYER, TURN_DEALER} turnT;

	typedef enum logic [1:0] {CMD_NONE, CMD_DEAL, CMD_HIT, CMD_STAND} commandT;

	// 9 bits per hand
	typedef struct packed {
		sumT   sum;
		countT count;
		logic  busted;
	} handInfoT;

	typedef struct packed {
		gameStateT state;
		turnT      turn;
		logic      done;
	} gameStatusT;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apbReqT;

	// game rule constants
	localparam countT HAND_MAX      = 3'd5;
	localparam sumT   BLACKJACK_SUM = 5'd21;
	localparam sumT   DEALER_STAND  = 5'd17;

	// byte offsets of the register block
	localparam logic [3:0] ADDR_CMD    = 4'h0;
	localparam logic [3:0] ADDR_CARD   = 4'h4;
	localparam logic [3:0] ADDR_STATUS = 4'h8;
	localparam logic [3:0] ADDR_COUNTS = 4'hC;

endpackage

//--- design/blackjackTop.sv
/*
	top level of the blackjack engine
	register block, card shoe, round fsm and two hands
*/
`timescale 1ns/1ps

module blackjackTop
	import blackjackPkg::*;
#(
	parameter int SHOE_DEPTH = 32,
	localparam int LEVEL_W = $clog2(SHOE_DEPTH) + 1
) (
	input  logic        i_clk,
	input  logic        i_reset,
	input  apbReqT      i_apb,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr
);

	// register block to shoe and game
	commandT cmd;
	logic cardPush;
	cardT pushCard;
	// shoe status and head card
	logic shoeFull;
	logic shoeEmpty;
	logic [LEVEL_W-1:0] shoeLevel;
	cardT headCard;
	// game controls
	logic draw;
	logic playerTake;
	logic dealerTake;
	logic clearHands;
	gameStatusT status;
	handInfoT playerInfo;
	handInfoT dealerInfo;

	apbRegs #(.SHOE_DEPTH(SHOE_DEPTH)) regs (
		.i_clk(i_clk), .i_reset(i_reset), .i_apb(i_apb),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.o_cmd(cmd), .o_cardPush(cardPush), .o_card(pushCard),
		.i_shoeFull(shoeFull), .i_shoeLevel(shoeLevel), .i_status(status),
		.i_player(playerInfo), .i_dealer(dealerInfo)
	);

	cardShoe #(.SHOE_DEPTH(SHOE_DEPTH)) shoe (
		.i_clk(i_clk), .i_reset(i_reset), .i_push(cardPush), .i_card(pushCard),
		.i_draw(draw), .o_head(headCard), .o_full(shoeFull), .o_empty(shoeEmpty),
		.o_level(shoeLevel)
	);

	blackjackGame game (
		.i_clk(i_clk), .i_reset(i_reset), .i_cmd(cmd), .i_shoeEmpty(shoeEmpty),
		.i_player(playerInfo), .i_dealer(dealerInfo), .o_draw(draw),
		.o_playerTake(playerTake), .o_dealerTake(dealerTake),
		.o_clearHands(clearHands), .o_status(status)
	);

	// both hands latch the same head card
	handController playerHand (
		.i_clk(i_clk), .i_reset(i_reset), .i_clear(clearHands),
		.i_take(playerTake), .i_card(headCard), .o_hand(playerInfo)
	);

	handController dealerHand (
		.i_clk(i_clk), .i_reset(i_reset), .i_clear(clearHands),
		.i_take(dealerTake), .i_card(headCard), .o_hand(dealerInfo)
	);

endmodule

//--- design/cardShoe.sv
/*
	card shoe, circular buffer of loaded cards
	host pushes at the tail, game draws from the head
*/
`timescale 1ns/1ps

module cardShoe
	import blackjackPkg::*;
#(
	parameter int SHOE_DEPTH = 32,
	localparam int PTR_W = $clog2(SHOE_DEPTH),
	localparam int LEVEL_W = PTR_W + 1
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_push,
	input  cardT               i_card,
	input  logic               i_draw,
	output cardT               o_head,
	output logic               o_full,
	output logic               o_empty,
	output logic [LEVEL_W-1:0] o_level
);

	cardT mem [SHOE_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [LEVEL_W-1:0] level;
	logic pushOk;
	logic drawOk;

	// drop pushes on a full shoe, ignore draws on an empty one
	assign pushOk = i_push && !o_full;
	assign drawOk = i_draw && !o_empty;

	// card storage
	always_ff @(posedge i_clk) begin
		if (pushOk)
			mem[wrPtr] <= i_card;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end else begin
			if (pushOk)
				wrPtr <= wrPtr + 1'b1;
			if (drawOk)
				rdPtr <= rdPtr + 1'b1;
			// push and draw together leave the level alone
			case ({pushOk, drawOk})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	assign o_full  = level == LEVEL_W'(SHOE_DEPTH);
	assign o_empty = level == '0;
	assign o_level = level;
	// head card visible without a draw
	assign o_head  = o_empty ? '0 : mem[rdPtr];

	// the game only draws while cards remain
	drawNotEmpty: assert property (@(posedge i_clk) disable iff (i_reset)
		i_draw |-> !o_empty)
		else $error("cardShoe: draw from an empty shoe");

endmodule

//--- design/handController.sv
/*
	one blackjack hand of up to five cards
	card count, best soft or hard total and bust flag
*/
`timescale 1ns/1ps

module handController
	import blackjackPkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_clear,
	input  logic     i_take,
	input  cardT     i_card,
	output handInfoT o_hand
);

	cardT cards [HAND_MAX];
	countT count;
	// internal sums are wider, five tens would overflow sumT
	logic [5:0] hardSum;
	logic [5:0] bestSum;
	logic hasAce;

	// face cards count ten, ace counts one here
	function automatic logic [5:0] cardValue(input cardT card);
		if (card >= 4'd10)
			return 6'd10;
		return {2'b00, card};
	endfunction

	// card slots, only the first count entries are valid
	always_ff @(posedge i_clk) begin
		if (i_take && !i_clear && count < HAND_MAX)
			cards[count] <= i_card;
	end

	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset)
			count <= '0;
		else if (i_clear)
			count <= '0;
		else if (i_take && count < HAND_MAX)
			count <= count + 1'b1;
	end

	// hard total over the held cards
	always_comb begin
		hardSum = '0;
		hasAce  = 1'b0;
		for (int i = 0; i < HAND_MAX; i++) begin
			if (countT'(i) < count) begin
				hardSum = hardSum + cardValue(cards[i]);
				if (cards[i] == 4'd1)
					hasAce = 1'b1;
			end
		end
	end

	// one ace may count eleven if that stays at 21 or below
	assign bestSum = (hasAce && (hardSum + 6'd10) <= 6'd21) ? hardSum + 6'd10 : hardSum;

	// saturate, a legal round never passes 31
	assign o_hand.sum    = (bestSum > 6'd31) ? 5'd31 : bestSum[4:0];
	assign o_hand.count  = count;
	assign o_hand.busted = hardSum > 6'd21;

	// game stops dealing at five cards
	takeBelowMax: assert property (@(posedge i_clk) disable iff (i_reset)
		i_take |-> count < HAND_MAX)
		else $error("handController: take with a full hand");

endmodule

//--- tests/blackjackTb.sv
/*
	testbench for the blackjack engine
	apb driver tasks, reset and idle checks, file driven rounds, shoe overflow
*/
`timescale 1ns/1ps

module blackjackTb
	import blackjackPkg::*;
#(
	parameter int SHOE_DEPTH = 32
) ();

	// status reads per wait loop
	localparam int POLL_LIMIT = 100;

	logic clk;
	logic reset;
	apbReqT apb;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	int seed;
	int testErrors;
	int passCount;
	int failCount;

	blackjackTop #(.SHOE_DEPTH(SHOE_DEPTH)) dut_i (
		.i_clk(clk), .i_reset(reset), .i_apb(apb),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	task automatic checkValue(input string name, input int got, input int expected);
		assert (got == expected)
		else begin
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, expected);
			testErrors++;
		end
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			$display("test %s passed", name);
			passCount++;
		end else begin
			$display("test %s failed", name);
			failCount++;
		end
		testErrors = 0;
	endtask

	// setup phase, then access phase, inputs change on the falling edge
	task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = 1'b1;
		apb.paddr = addr;
		apb.pwdata = data;
		@(negedge clk);
		apb.penable = 1'b1;
		@(negedge clk);
		// slave error registered at the access edge
		err = pslverr;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
		apb.pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [3:0] addr, output logic [31:0] data);
		@(negedge clk);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = 1'b0;
		apb.paddr = addr;
		@(negedge clk);
		apb.penable = 1'b1;
		// mid access phase, read mux settled
		#10;
		data = prdata;
		@(negedge clk);
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic sendCommand(input commandT cmd);
		logic err;
		apbWrite(ADDR_CMD, {30'd0, cmd}, err);
		checkValue("pslverr", int'(err), 0);
	endtask

	task automatic pushCard(input int card);
		logic err;
		apbWrite(ADDR_CARD, 32'(card), err);
		checkValue("pslverr", int'(err), 0);
	endtask

	task automatic waitForDone(output logic [31:0] word);
		int polls;
		polls = 0;
		apbRead(ADDR_STATUS, word);
		while (!word[6] && polls < POLL_LIMIT) begin
			polls++;
			apbRead(ADDR_STATUS, word);
		end
		assert (word[6])
		else begin
			$display("timeout at %0t while waiting for the round to finish", $time);
			testErrors++;
		end
	endtask

	// stops early when the round is already over
	task automatic waitForChoice(output logic ok);
		logic [31:0] word;
		int polls;
		polls = 0;
		apbRead(ADDR_STATUS, word);
		while (word[3:0] != S_PLAYER_CHOICE && !word[6] && polls < POLL_LIMIT) begin
			polls++;
			apbRead(ADDR_STATUS, word);
		end
		ok = word[3:0] == S_PLAYER_CHOICE;
		assert (!word[6])
		else begin
			$display("round ended at %0t before the player could decide", $time);
			testErrors++;
		end
		assert (ok || word[6])
		else begin
			$display("timeout at %0t while waiting for the player decision state", $time);
			testErrors++;
		end
	endtask

	task automatic checkReset();
		logic [31:0] word;
		apbRead(ADDR_STATUS, word);
		checkValue("state", int'(word[3:0]), int'(S_IDLE));
		checkValue("turn", int'(word[5:4]), int'(TURN_NONE));
		checkValue("done", int'(word[6]), 0);
		checkValue("playerSum", int'(word[12:8]), 0);
		checkValue("dealerSum", int'(word[20:16]), 0);
		apbRead(ADDR_COUNTS, word);
		checkValue("playerCount", int'(word[2:0]), 0);
		checkValue("dealerCount", int'(word[6:4]), 0);
		checkValue("shoeLevel", int'(word[15:8]), 0);
		checkValue("pready", int'(pready), 1);
		finishTest("reset");
	endtask

	// hit and stand have no effect between rounds
	task automatic checkIdleCommands();
		logic [31:0] word;
		sendCommand(CMD_HIT);
		apbRead(ADDR_STATUS, word);
		checkValue("state", int'(word[3:0]), int'(S_IDLE));
		sendCommand(CMD_STAND);
		apbRead(ADDR_STATUS, word);
		checkValue("state", int'(word[3:0]), int'(S_IDLE));
		finishTest("idle commands");
	endtask

	task automatic playRound(input string line, input int roundNo);
		int cards [10];
		int stall;
		int expPlayer;
		int expDealer;
		int fields;
		int nCards;
		int nHits;
		int preload;
		int expState;
		logic [63:0] decisions;
		logic [7:0] outcome;
		logic [7:0] choice;
		logic [31:0] word;
		logic ok;
		fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %s %d %d %s", stall,
			cards[0], cards[1], cards[2], cards[3], cards[4],
			cards[5], cards[6], cards[7], cards[8], cards[9],
			decisions, expPlayer, expDealer, outcome);
		assert (fields == 15)
		else begin
			$display("round %0d has a malformed line in the test data file", roundNo);
			testErrors++;
		end
		if (fields != 15) begin
			finishTest($sformatf("round %0d", roundNo));
			return;
		end
		nCards = 0;
		for (int i = 0; i < 10; i++)
			if (cards[i] != 0)
				nCards = i + 1;
		// string is right aligned, first decision sits in the highest nonzero byte
		nHits = 0;
		for (int i = 0; i < 8; i++)
			if (decisions[i*8 +: 8] == "H")
				nHits++;
		case (outcome)
			"W": expState = int'(S_RESULT_WIN);
			"L": expState = int'(S_RESULT_LOSE);
			default: expState = int'(S_RESULT_TIE);
		endcase
		preload = (stall == 0) ? nCards : stall;
		for (int i = 0; i < preload; i++)
			pushCard(cards[i]);
		sendCommand(CMD_DEAL);
		if (stall != 0) begin
			// shoe ran dry, round has to hold
			repeat (10) begin
				apbRead(ADDR_STATUS, word);
				checkValue("done", int'(word[6]), 0);
			end
			for (int i = preload; i < nCards; i++)
				pushCard(cards[i]);
		end
		for (int i = 7; i >= 0; i--) begin
			choice = decisions[i*8 +: 8];
			if (choice == "H" || choice == "S") begin
				waitForChoice(ok);
				if (!ok)
					break;
				// a deal in the middle of a round is dropped
				sendCommand(CMD_DEAL);
				apbRead(ADDR_STATUS, word);
				checkValue("state", int'(word[3:0]), int'(S_PLAYER_CHOICE));
				sendCommand(choice == "H" ? CMD_HIT : CMD_STAND);
			end
		end
		waitForDone(word);
		checkValue("state", int'(word[3:0]), expState);
		checkValue("playerSum", int'(word[12:8]), expPlayer);
		checkValue("dealerSum", int'(word[20:16]), expDealer);
		// player holds two cards plus one per hit, dealer the rest
		apbRead(ADDR_COUNTS, word);
		checkValue("playerCount", int'(word[2:0]), 2 + nHits);
		checkValue("dealerCount", int'(word[6:4]), nCards - 2 - nHits);
		checkValue("shoeLevel", int'(word[15:8]), 0);
		finishTest($sformatf("round %0d", roundNo));
	endtask

	task automatic playFileRounds();
		int fd;
		int roundNo;
		string line;
		fd = $fopen("tests/blackjackTests.txt", "r");
		assert (fd != 0)
		else begin
			$display("cannot open tests/blackjackTests.txt");
			failCount++;
		end
		if (fd == 0)
			return;
		roundNo = 0;
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			// comment and blank lines
			if (line.len() < 2 || line[0] == "#")
				continue;
			roundNo++;
			playRound(line, roundNo);
		end
		$fclose(fd);
	endtask

	// one card too many, last push is refused
	task automatic checkShoeOverflow();
		logic [31:0] word;
		logic err;
		int card;
		for (int i = 0; i <= SHOE_DEPTH; i++) begin
			card = int'($unsigned($random(seed)) % 13) + 1;
			apbWrite(ADDR_CARD, 32'(card), err);
			checkValue("pslverr", int'(err), (i == SHOE_DEPTH) ? 1 : 0);
		end
		apbRead(ADDR_COUNTS, word);
		checkValue("shoeLevel", int'(word[15:8]), SHOE_DEPTH);
		finishTest("shoe overflow");
	endtask

	initial begin
		seed = 43;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		clk = 1'b0;
		reset = 1'b1;
		apb = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		checkReset();
		checkIdleCommands();
		playFileRounds();
		checkShoeOverflow();
		$display("summary: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- tests/blackjackTests.txt
# stall c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 decisions playerSum dealerSum outcome
# cards in hex, shoe order: dealer up card, two player cards, hits, dealer draws; 0 = none
# stall = cards loaded before the deal (0 loads all); decisions H or S, - for none; W L T
0 9 a 8 8 0 0 0 0 0 0 S 18 17 W
0 a 7 9 8 0 0 0 0 0 0 S 16 18 L
0 d 9 b 9 0 0 0 0 0 0 S 19 19 T
0 6 a a a 8 0 0 0 0 0 S 20 24 W
0 5 1 c 0 0 0 0 0 0 0 - 21 5 W
0 7 a 6 9 0 0 0 0 0 0 H 25 7 L
0 a 2 3 4 2 5 0 0 0 0 HHH 16 10 W
0 8 1 5 8 4 9 0 0 0 0 HHS 18 17 W
0 2 a 9 3 1 4 0 0 0 0 S 19 20 L
0 2 a 6 2 3 2 4 0 0 0 S 16 13 L
0 3 1 2 c 4 1 0 0 0 0 HS 13 18 L
0 1 4 3 a 4 5 9 8 0 0 HHS 21 23 W
0 9 1 1 9 1 0 0 0 0 0 HS 21 20 W
0 5 d c 5 a 0 0 0 0 0 S 20 20 T
0 2 a 2 2 3 a 0 0 0 0 S 12 17 L
2 4 5 6 1 9 d 3 0 0 0 HHS 21 17 W
1 c 1 b 0 0 0 0 0 0 0 - 21 10 W

//--- verilog.f
design/blackjackPkg.sv
design/cardShoe.sv
design/handController.sv
design/apbRegs.sv
design/blackjackGame.sv
design/blackjackTop.sv
tests/blackjackTb.sv
